// File: project.f
design/iob_soc_pkg.sv
design/iob_split.sv
design/iob_int_mem.sv
design/iob_soc_boot.sv
design/iob_gpio.sv
design/iob_soc.sv
dv/iob_soc_chk.sv
dv/iob_soc_scoreboard.sv
dv/iob_soc_tb.sv

// File: iob_soc_boot.hex
// boot rom image: one 32-bit hex word per line, word addresses 0 to 15
00000093
00100113
0020a023
00408193
ff010113
00112623
3e800513
0ff00593
a5a5a5a5
5a5a5a5a
deadbeef
c0ffee01
12345678
87654321
0000006f
00008067

// File: dv/iob_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_tb;

   import iob_soc_pkg::*;

   localparam int SEED         = 92167;
   localparam int N_BOOT_FETCH = 24;
   localparam int N_FILL       = 2**SRAM_ADDR_W;
   localparam int N_RAND_DATA  = 160;
   localparam int N_SRAM_FETCH = 16;
   localparam int N_ARB        = 200;
   localparam int N_GPIO       = 8;
   // gpio rounds take about 9 cycles each
   localparam int TEST_LEN     = N_BOOT_FETCH + 2 * N_FILL + N_RAND_DATA + N_SRAM_FETCH +
                                 N_ARB + 9 * N_GPIO;
   localparam int WATCHDOG_CYC = 4 * TEST_LEN;

   logic              clk;
   logic              rst_n;
   iob_req_t          ibus_req;
   iob_req_t          dbus_req;
   iob_resp_t         ibus_resp;
   iob_resp_t         dbus_resp;
   logic [GPIO_W-1:0] gpio_in;
   logic [GPIO_W-1:0] gpio_out;
   logic              cpu_rst;
   int                err_cnt;
   int                chk_cnt;
   int                err_mark;
   int                fetch_sent;

   iob_soc i_iob_soc (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .ibus_req_i (ibus_req),
      .ibus_resp_o(ibus_resp),
      .dbus_req_i (dbus_req),
      .dbus_resp_o(dbus_resp),
      .gpio_i     (gpio_in),
      .gpio_o     (gpio_out),
      .cpu_rst_o  (cpu_rst)
   );

   iob_soc_scoreboard i_scoreboard (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .ibus_req_i (ibus_req),
      .ibus_resp_i(ibus_resp),
      .dbus_req_i (dbus_req),
      .dbus_resp_i(dbus_resp),
      .gpio_in_i  (gpio_in),
      .gpio_out_i (gpio_out),
      .cpu_rst_i  (cpu_rst),
      .err_cnt_o  (err_cnt),
      .chk_cnt_o  (chk_cnt)
   );

   // protocol checker on the top level ports and the internal slave buses
   bind iob_soc iob_soc_chk i_chk (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ibus_req_i (ibus_req_i),
      .ibus_resp_i(ibus_resp_o),
      .dbus_req_i (dbus_req_i),
      .dbus_resp_i(dbus_resp_o),
      .s_req_i    (slaves_req),
      .boot_i     (boot),
      .cpu_rst_i  (cpu_rst_o)
   );

   initial begin
      clk = 1'b0;
   end

   always #5 clk = ~clk;

   function automatic logic [ADDR_W-1:0] slave_addr(input int slave, input int offset);
      return {SLAVE_SEL_W'(slave), (ADDR_W-SLAVE_SEL_W)'(offset & 32'hfffc)};
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int cycles);
      ibus_req.avalid = 1'b0;
      dbus_req.avalid = 1'b0;
      repeat (cycles) next_cycle();
   endtask

   // data ready is always high, so one cycle per request
   task automatic data_op(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                          input logic [DATA_W/8-1:0] wstrb);
      dbus_req = '{avalid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      next_cycle();
      dbus_req.avalid = 1'b0;
   endtask

   // hold the fetch until ready
   task automatic fetch(input logic [ADDR_W-1:0] addr);
      logic accepted;
      ibus_req = '{avalid: 1'b1, addr: addr, wdata: '0, wstrb: '0};
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge clk);
         accepted = ibus_resp.ready;
         next_cycle();
      end
      ibus_req.avalid = 1'b0;
      fetch_sent++;
   endtask

   task automatic end_test(input string name);
      idle(3);
      $display("test %-18s done, %0d errors", name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   initial begin
      logic i_acc;
      void'($urandom(SEED));
      rst_n      = 1'b0;
      ibus_req   = '0;
      dbus_req   = '0;
      gpio_in    = '0;
      err_mark   = 0;
      fetch_sent = 0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // cpu reset ends two cycles after release, fetches hit the rom
      idle(4);
      for (int n = 0; n < N_BOOT_FETCH; n++) begin
         fetch(slave_addr($urandom_range(3, 0), $urandom));
      end
      end_test("reset and boot");

      for (int n = 0; n < N_FILL; n++) begin
         data_op(slave_addr(SLAVE_MEM, 4 * n), $urandom, 4'hf);
      end
      for (int n = 0; n < N_RAND_DATA; n++) begin
         data_op(slave_addr(SLAVE_MEM, $urandom), $urandom, 4'($urandom));
         if ($urandom_range(3, 0) == 0) begin
            idle(1);
         end
      end
      // read every word back after the partial writes
      for (int n = 0; n < N_FILL; n++) begin
         data_op(slave_addr(SLAVE_MEM, 4 * n), 32'h0, 4'h0);
      end
      end_test("data sram");

      data_op(slave_addr(SLAVE_BOOT, 0), 32'h0, 4'hf);
      idle(3);
      for (int n = 0; n < N_SRAM_FETCH; n++) begin
         fetch(slave_addr(SLAVE_MEM, $urandom));
      end
      data_op(slave_addr(SLAVE_BOOT, 0), 32'h0, 4'h0);
      data_op(slave_addr(SLAVE_BOOT, 0), 32'h0, 4'hf);
      end_test("boot exit");

      for (int n = 0; n < N_ARB; n++) begin
         if (!ibus_req.avalid && $urandom_range(3, 0) != 0) begin
            ibus_req = '{avalid: 1'b1, addr: slave_addr(SLAVE_MEM, $urandom), wdata: '0,
                         wstrb: '0};
         end
         dbus_req = '{avalid: ($urandom_range(2, 0) != 0), addr: slave_addr(SLAVE_MEM, $urandom),
                      wdata: $urandom, wstrb: ($urandom_range(1, 0) != 0) ? 4'($urandom) : 4'h0};
         @(negedge clk);
         i_acc = ibus_req.avalid && ibus_resp.ready;
         next_cycle();
         if (i_acc) begin
            ibus_req.avalid = 1'b0;
            fetch_sent++;
         end
      end
      dbus_req.avalid = 1'b0;
      if (ibus_req.avalid) begin
         fetch(ibus_req.addr);
      end
      idle(3);
      i_scoreboard.check_fetch_count(fetch_sent);
      end_test("arbitration");

      for (int n = 0; n < N_GPIO; n++) begin
         data_op(slave_addr(SLAVE_GPIO, 0), $urandom, 4'($urandom_range(15, 1)));
         data_op(slave_addr(SLAVE_GPIO, 4), $urandom, 4'hf);
         data_op(slave_addr(SLAVE_GPIO, 0), 32'h0, 4'h0);
         gpio_in = GPIO_W'($urandom);
         idle(3);
         data_op(slave_addr(SLAVE_GPIO, 4), 32'h0, 4'h0);
         data_op(slave_addr(3, $urandom), $urandom, 4'hf);
         data_op(slave_addr(3, $urandom), 32'h0, 4'h0);
      end
      end_test("gpio and unmapped");

      $display("tests 5, checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/iob_soc_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_scoreboard (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  iob_soc_pkg::iob_req_t          ibus_req_i,
   input  iob_soc_pkg::iob_resp_t         ibus_resp_i,
   input  iob_soc_pkg::iob_req_t          dbus_req_i,
   input  iob_soc_pkg::iob_resp_t         dbus_resp_i,
   input  logic [iob_soc_pkg::GPIO_W-1:0] gpio_in_i,
   input  logic [iob_soc_pkg::GPIO_W-1:0] gpio_out_i,
   input  logic                           cpu_rst_i,
   output int                             err_cnt_o,
   output int                             chk_cnt_o
);

   import iob_soc_pkg::*;

   logic [DATA_W-1:0]      sram_m [2**SRAM_ADDR_W];
   logic [DATA_W-1:0]      rom_m  [2**BOOTROM_ADDR_W];
   logic                   boot_m;
   logic [GPIO_W-1:0]      gpio_m;
   logic [GPIO_W-1:0]      gpio_hist1;
   logic [GPIO_W-1:0]      gpio_hist2;
   logic                   i_pend;
   logic                   d_pend;
   logic                   chg_pend;
   logic [DATA_W-1:0]      i_exp;
   logic [DATA_W-1:0]      d_exp;
   logic [SRAM_ADDR_W-1:0] widx;
   int                     sel;
   int                     rst_left;
   int                     fetch_done = 0;
   int                     err_cnt = 0;
   int                     chk_cnt = 0;

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

   initial begin
      $readmemh(BOOT_HEXFILE, rom_m);
   end

   task automatic compare_value(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_fetch_count(input int sent);
      compare_value("completed fetches", DATA_W'(sent), DATA_W'(fetch_done));
   endtask

   // sampled mid cycle, requests and responses are settled by then
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         boot_m     = 1'b1;
         gpio_m     = '0;
         gpio_hist1 = '0;
         gpio_hist2 = '0;
         i_pend     = 1'b0;
         d_pend     = 1'b0;
         chg_pend   = 1'b0;
         rst_left   = 2;
      end else begin
         // responses owed by last cycle's reads
         compare_value("ibus_resp_o.rvalid", DATA_W'(i_pend), DATA_W'(ibus_resp_i.rvalid));
         compare_value("dbus_resp_o.rvalid", DATA_W'(d_pend), DATA_W'(dbus_resp_i.rvalid));
         if (i_pend) begin
            compare_value("ibus_resp_o.rdata", i_exp, ibus_resp_i.rdata);
         end
         if (d_pend) begin
            compare_value("dbus_resp_o.rdata", d_exp, dbus_resp_i.rdata);
         end
         if (ibus_resp_i.rvalid) begin
            fetch_done++;
         end
         compare_value("cpu_rst_o", DATA_W'(rst_left != 0 || chg_pend), DATA_W'(cpu_rst_i));
         compare_value("gpio_o", DATA_W'(gpio_m), DATA_W'(gpio_out_i));
         if (rst_left != 0) begin
            rst_left--;
         end

         sel  = int'(dbus_req_i.addr[ADDR_W-1 -: SLAVE_SEL_W]);
         widx = dbus_req_i.addr[SRAM_ADDR_W+1:2];
         // data bus never stalls, unmapped space included
         if (dbus_req_i.avalid) begin
            compare_value("dbus_resp_o.ready", DATA_W'(1'b1), DATA_W'(dbus_resp_i.ready));
         end
         // data bus takes the sram port, rom fetches never wait
         if (ibus_req_i.avalid) begin
            compare_value("ibus_resp_o.ready",
                          DATA_W'(boot_m || !(dbus_req_i.avalid && sel == SLAVE_MEM)),
                          DATA_W'(ibus_resp_i.ready));
         end

         // fetch sees the boot flag from before this cycle's write
         i_pend = ibus_req_i.avalid && ibus_resp_i.ready && (ibus_req_i.wstrb == '0);
         if (i_pend) begin
            i_exp = boot_m ? rom_m[ibus_req_i.addr[BOOTROM_ADDR_W+1:2]]
                           : sram_m[ibus_req_i.addr[SRAM_ADDR_W+1:2]];
         end

         d_pend   = dbus_req_i.avalid && (dbus_req_i.wstrb == '0);
         chg_pend = 1'b0;
         if (d_pend) begin
            case (sel)
               SLAVE_MEM:  d_exp = sram_m[widx];
               SLAVE_BOOT: d_exp = DATA_W'(boot_m);
               SLAVE_GPIO: d_exp = dbus_req_i.addr[2] ? DATA_W'(gpio_hist2) : DATA_W'(gpio_m);
               default:    d_exp = '0;
            endcase
         end else if (dbus_req_i.avalid) begin
            if (sel == SLAVE_MEM) begin
               for (int b = 0; b < DATA_W/8; b++) begin
                  if (dbus_req_i.wstrb[b]) begin
                     sram_m[widx][b*8 +: 8] = dbus_req_i.wdata[b*8 +: 8];
                  end
               end
            end else if (sel == SLAVE_BOOT && dbus_req_i.wstrb[0]) begin
               chg_pend = (dbus_req_i.wdata[0] != boot_m);
               boot_m   = dbus_req_i.wdata[0];
            end else if (sel == SLAVE_GPIO && dbus_req_i.wstrb[0] && !dbus_req_i.addr[2]) begin
               gpio_m = dbus_req_i.wdata[GPIO_W-1:0];
            end
         end

         // gpio input seen through two register stages
         gpio_hist2 = gpio_hist1;
         gpio_hist1 = gpio_in_i;
      end
   end

endmodule

`default_nettype wire

// File: dv/iob_soc_chk.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_chk (
   input logic                                              clk_i,
   input logic                                              rst_n_i,
   input iob_soc_pkg::iob_req_t                             ibus_req_i,
   input iob_soc_pkg::iob_resp_t                            ibus_resp_i,
   input iob_soc_pkg::iob_req_t                             dbus_req_i,
   input iob_soc_pkg::iob_resp_t                            dbus_resp_i,
   input iob_soc_pkg::iob_req_t [iob_soc_pkg::N_SLAVES-1:0] s_req_i,
   input logic                                              boot_i,
   input logic                                              cpu_rst_i
);

   import iob_soc_pkg::*;

   logic                i_rd_acc;
   logic                d_rd_acc;
   logic                boot_chg;
   logic [N_SLAVES-1:0] s_avalid;

   assign i_rd_acc = ibus_req_i.avalid && ibus_resp_i.ready && (ibus_req_i.wstrb == '0);
   assign d_rd_acc = dbus_req_i.avalid && dbus_resp_i.ready && (dbus_req_i.wstrb == '0);

   // write that flips the boot flag
   assign boot_chg = s_req_i[SLAVE_BOOT].avalid && s_req_i[SLAVE_BOOT].wstrb[0] &&
                     (s_req_i[SLAVE_BOOT].wdata[0] != boot_i);

   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_avalid[i] = s_req_i[i].avalid;
      end
   end

   ibus_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ibus_resp_i.rvalid == $past(i_rd_acc))
      else $error("ibus rvalid not in the cycle after an accepted read");

   dbus_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dbus_resp_i.rvalid == $past(d_rd_acc))
      else $error("dbus rvalid not in the cycle after an accepted read");

   cpu_rst_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      boot_chg |=> cpu_rst_i ##1 !cpu_rst_i)
      else $error("cpu reset pulse is not exactly one cycle");

   cpu_rst_cause_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(cpu_rst_i) |-> $past(boot_chg))
      else $error("cpu reset rose without a boot flag change");

   one_slave_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(s_avalid))
      else $error("more than one slave sees avalid");

endmodule

`default_nettype wire

// File: design/iob_soc.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  iob_soc_pkg::iob_req_t          ibus_req_i,
   output iob_soc_pkg::iob_resp_t         ibus_resp_o,
   input  iob_soc_pkg::iob_req_t          dbus_req_i,
   output iob_soc_pkg::iob_resp_t         dbus_resp_o,
   input  logic [iob_soc_pkg::GPIO_W-1:0] gpio_i,
   output logic [iob_soc_pkg::GPIO_W-1:0] gpio_o,
   output logic                           cpu_rst_o
);

   import iob_soc_pkg::*;

   // per slave data bus, memory first, then boot control and gpio
   iob_req_t  [N_SLAVES-1:0] slaves_req;
   iob_resp_t [N_SLAVES-1:0] slaves_resp;

   logic boot;

   iob_split pbus_split (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .m_req_i (dbus_req_i),
      .m_resp_o(dbus_resp_o),
      .s_req_o (slaves_req),
      .s_resp_i(slaves_resp)
   );

   // instruction bus goes straight to internal memory
   iob_int_mem int_mem0 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .boot_i  (boot),
      .i_req_i (ibus_req_i),
      .i_resp_o(ibus_resp_o),
      .d_req_i (slaves_req[SLAVE_MEM]),
      .d_resp_o(slaves_resp[SLAVE_MEM])
   );

   iob_soc_boot soc_boot (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (slaves_req[SLAVE_BOOT]),
      .resp_o   (slaves_resp[SLAVE_BOOT]),
      .boot_o   (boot),
      .cpu_rst_o(cpu_rst_o)
   );

   iob_gpio gpio0 (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (slaves_req[SLAVE_GPIO]),
      .resp_o (slaves_resp[SLAVE_GPIO]),
      .gpio_i (gpio_i),
      .gpio_o (gpio_o)
   );

endmodule

`default_nettype wire

// File: design/iob_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module iob_gpio (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  iob_soc_pkg::iob_req_t          req_i,
   output iob_soc_pkg::iob_resp_t         resp_o,
   input  logic [iob_soc_pkg::GPIO_W-1:0] gpio_i,
   output logic [iob_soc_pkg::GPIO_W-1:0] gpio_o
);

   import iob_soc_pkg::*;

   logic              wr_en;
   logic              rd_en;
   logic [GPIO_W-1:0] out_q;
   logic [GPIO_W-1:0] sync1_q;
   logic [GPIO_W-1:0] sync2_q;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;

   // offset 4 is the input register, read only
   assign wr_en = req_i.avalid && req_i.wstrb[0] && !req_i.addr[2];
   assign rd_en = req_i.avalid && (req_i.wstrb == '0);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_q    <= '0;
         sync1_q  <= '0;
         sync2_q  <= '0;
         rvalid_q <= 1'b0;
      end else begin
         sync1_q  <= gpio_i;
         sync2_q  <= sync1_q;
         rvalid_q <= rd_en;
         if (wr_en) begin
            out_q <= req_i.wdata[GPIO_W-1:0];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= req_i.addr[2] ? DATA_W'(sync2_q) : DATA_W'(out_q);
      end
   end

   assign resp_o = '{rdata: rdata_q, rvalid: rvalid_q, ready: 1'b1};
   assign gpio_o = out_q;

endmodule

`default_nettype wire

// File: design/iob_soc_boot.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_boot (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  iob_soc_pkg::iob_req_t  req_i,
   output iob_soc_pkg::iob_resp_t resp_o,
   output logic                   boot_o,
   output logic                   cpu_rst_o
);

   import iob_soc_pkg::*;

   logic              wr_en;
   logic              rd_en;
   logic              boot_q;
   logic              rst_hold_q;
   logic              cpu_rst_q;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;

   assign wr_en = req_i.avalid && req_i.wstrb[0];
   assign rd_en = req_i.avalid && (req_i.wstrb == '0);

   // cpu reset spans system reset plus one cycle, then pulses on a boot change
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         boot_q     <= 1'b1;
         rst_hold_q <= 1'b1;
         cpu_rst_q  <= 1'b1;
         rvalid_q   <= 1'b0;
      end else begin
         rst_hold_q <= 1'b0;
         cpu_rst_q  <= rst_hold_q || (wr_en && (req_i.wdata[0] != boot_q));
         rvalid_q   <= rd_en;
         if (wr_en) begin
            boot_q <= req_i.wdata[0];
         end
      end
   end

   // only bit 0 exists
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= DATA_W'(boot_q);
      end
   end

   assign resp_o    = '{rdata: rdata_q, rvalid: rvalid_q, ready: 1'b1};
   assign boot_o    = boot_q;
   assign cpu_rst_o = cpu_rst_q;

endmodule

`default_nettype wire

// File: design/iob_int_mem.sv
`timescale 1ns/1ps
`default_nettype none

module iob_int_mem (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   boot_i,
   input  iob_soc_pkg::iob_req_t  i_req_i,
   output iob_soc_pkg::iob_resp_t i_resp_o,
   input  iob_soc_pkg::iob_req_t  d_req_i,
   output iob_soc_pkg::iob_resp_t d_resp_o
);

   import iob_soc_pkg::*;

   logic [DATA_W-1:0] sram [2**SRAM_ADDR_W];
   logic [DATA_W-1:0] rom  [2**BOOTROM_ADDR_W];

   logic                   i_sram_req;
   logic                   i_ready;
   logic                   i_accept;
   logic [SRAM_ADDR_W-1:0] sram_addr;
   logic [DATA_W/8-1:0]    sram_we;
   logic [DATA_W-1:0]      sram_rdata_q;
   logic [DATA_W-1:0]      rom_rdata_q;
   logic                   i_rom_q;
   logic                   i_rvalid_q;
   logic                   d_rvalid_q;

   initial begin
      $readmemh(BOOT_HEXFILE, rom);
   end

   // fetches use the sram only outside boot mode
   assign i_sram_req = i_req_i.avalid && !boot_i;
   // data bus wins the shared port, rom fetches never wait
   assign i_ready    = boot_i || !d_req_i.avalid;
   assign i_accept   = i_req_i.avalid && i_ready;

   assign sram_addr = d_req_i.avalid ? d_req_i.addr[SRAM_ADDR_W+1:2]
                                     : i_req_i.addr[SRAM_ADDR_W+1:2];
   assign sram_we   = d_req_i.avalid ? d_req_i.wstrb : '0;

   // one port, byte lane writes, old data on read
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < DATA_W/8; b++) begin
         if (sram_we[b]) begin
            sram[sram_addr][b*8 +: 8] <= d_req_i.wdata[b*8 +: 8];
         end
      end
      if (d_req_i.avalid || i_sram_req) begin
         sram_rdata_q <= sram[sram_addr];
      end
   end

   // boot rom wraps on the low word bits
   always_ff @(posedge clk_i) begin
      if (i_req_i.avalid && boot_i) begin
         rom_rdata_q <= rom[i_req_i.addr[BOOTROM_ADDR_W+1:2]];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
         i_rom_q    <= 1'b1;
      end else begin
         i_rvalid_q <= i_accept && (i_req_i.wstrb == '0);
         d_rvalid_q <= d_req_i.avalid && (d_req_i.wstrb == '0);
         if (i_accept) begin
            i_rom_q <= boot_i;
         end
      end
   end

   assign i_resp_o = '{rdata:  (i_rom_q ? rom_rdata_q : sram_rdata_q),
                       rvalid: i_rvalid_q,
                       ready:  i_ready};

   assign d_resp_o = '{rdata: sram_rdata_q, rvalid: d_rvalid_q, ready: 1'b1};

endmodule

`default_nettype wire

// File: design/iob_split.sv
`timescale 1ns/1ps
`default_nettype none

module iob_split (
   input  logic                                               clk_i,
   input  logic                                               rst_n_i,
   input  iob_soc_pkg::iob_req_t                              m_req_i,
   output iob_soc_pkg::iob_resp_t                             m_resp_o,
   output iob_soc_pkg::iob_req_t  [iob_soc_pkg::N_SLAVES-1:0] s_req_o,
   input  iob_soc_pkg::iob_resp_t [iob_soc_pkg::N_SLAVES-1:0] s_resp_i
);

   import iob_soc_pkg::*;

   logic [SLAVE_SEL_W-1:0] sel;
   logic                   s_ready;
   logic                   accept_rd;
   logic [SLAVE_SEL_W-1:0] sel_q;
   logic                   rd_q;

   assign sel = m_req_i.addr[ADDR_W-1 -: SLAVE_SEL_W];

   // only the addressed slave sees avalid
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_req_o[i]        = m_req_i;
         s_req_o[i].avalid = m_req_i.avalid && (int'(sel) == i);
      end
   end

   // unmapped space never stalls
   always_comb begin
      s_ready = 1'b1;
      for (int i = 0; i < N_SLAVES; i++) begin
         if (int'(sel) == i) begin
            s_ready = s_resp_i[i].ready;
         end
      end
   end

   assign accept_rd = m_req_i.avalid && s_ready && (m_req_i.wstrb == '0);

   // remember who owes the next read response
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_q  <= 1'b0;
         sel_q <= '0;
      end else begin
         rd_q <= accept_rd;
         if (accept_rd) begin
            sel_q <= sel;
         end
      end
   end

   // unmapped read answers with zero
   always_comb begin
      m_resp_o.ready  = s_ready;
      m_resp_o.rvalid = rd_q;
      m_resp_o.rdata  = '0;
      for (int i = 0; i < N_SLAVES; i++) begin
         if (int'(sel_q) == i) begin
            m_resp_o.rvalid = rd_q && s_resp_i[i].rvalid;
            m_resp_o.rdata  = s_resp_i[i].rdata;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/iob_soc_pkg.sv
`default_nettype none

package iob_soc_pkg;

   // bus geometry
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // data bus address map, slave select in the top address bits
   localparam int N_SLAVES    = 3;
   localparam int SLAVE_SEL_W = 2;
   localparam int SLAVE_MEM   = 0;
   localparam int SLAVE_BOOT  = 1;
   localparam int SLAVE_GPIO  = 2;

   // internal memory sizes, in words
   localparam int SRAM_ADDR_W    = 8;
   localparam int BOOTROM_ADDR_W = 4;

   localparam string BOOT_HEXFILE = "iob_soc_boot.hex";

   localparam int GPIO_W = 8;

   // native bus request, a read has wstrb all zero
   typedef struct packed {
      logic                avalid;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
   } iob_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_resp_t;

endpackage

`default_nettype wire
